//--- src/glay_control.sv
`timescale 1ns/1ns

`include "glay_settings.svh"

module glay_control (
  input  logic                     ap_clk,
  input  logic                     rst,
  input  logic                     ap_start,
  output logic                     ap_idle,
  output logic                     ap_ready,
  output logic                     ap_done,
  input  logic                     desc_valid,
  input  logic [`GLAY_ADDR_W-1:0]  desc_base_addr,
  input  logic [`GLAY_COUNT_W-1:0] desc_num_words,
  input  logic                     resp_fire,
  input  logic [`GLAY_ID_W-1:0]    resp_id,
  output logic                     setup_start,
  output glay_pkg::glay_desc_t     setup_desc
);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_finish
  } state_t;

  state_t                   state;
  logic                     start_reg;
  logic                     start_pulse;
  logic [`GLAY_COUNT_W-1:0] resp_count;
  logic [`GLAY_COUNT_W-1:0] last_index;
  logic                     setup_fire;

  // ------------------------------------------------------------
  // Host handshake outputs
  // ------------------------------------------------------------
  assign ap_idle     = (state == st_idle);
  assign ap_done     = (state == st_finish);
  // Same pulse acknowledges the host and kicks the setup reader
  assign ap_ready    = start_pulse;
  assign setup_start = start_pulse;

  // Only setup-tagged beats count toward completion
  assign setup_fire = resp_fire && (resp_id == `GLAY_ID_SETUP);
  assign last_index = setup_desc.num_words - `GLAY_COUNT_W'(1);

  // Descriptor follows the host while idle, last write wins
  always_ff @(posedge ap_clk) begin
    if (ap_idle && desc_valid) begin
      setup_desc.base_addr <= desc_base_addr;
      setup_desc.num_words <= desc_num_words;
    end
  end

  // ------------------------------------------------------------
  // Run FSM
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (rst) begin
      state       <= st_idle;
      start_reg   <= 1'b0;
      start_pulse <= 1'b0;
      resp_count  <= '0;
    end else begin
      start_reg   <= ap_start;
      start_pulse <= 1'b0;
      case (state)
        st_idle: begin
          // Start seen while busy never reaches here
          if (start_reg) begin
            state       <= st_run;
            start_pulse <= 1'b1;
            resp_count  <= '0;
          end
        end
        st_run: begin
          if (setup_fire) begin
            resp_count <= resp_count + `GLAY_COUNT_W'(1);
            // Final setup beat just left the response port
            if (resp_count == last_index) begin
              state <= st_finish;
            end
          end
        end
        // One cycle of ap_done, then back to idle
        default: state <= st_idle;
      endcase
    end
  end

endmodule : glay_control

//--- src/glay_fifo.sv
`timescale 1ns/1ns

`include "glay_settings.svh"

module glay_fifo #(
  parameter type payload_t = logic
) (
  input  logic     ap_clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int depth = `GLAY_FIFO_DEPTH;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             wr_fire;
  logic             rd_fire;

  // ------------------------------------------------------------
  // Status and read port
  // ------------------------------------------------------------
  assign in_ready  = (count != cnt_w'(depth));
  assign out_valid = (count != '0);
  // Head entry shown directly from storage
  assign out_data  = mem[rd_ptr];

  assign wr_fire = in_valid && in_ready;
  assign rd_fire = out_valid && out_ready;

  // Storage
  always_ff @(posedge ap_clk) begin
    if (wr_fire) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // ------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Explicit wrap, depth need not be a power of two
      if (wr_fire) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + ptr_w'(1);
      end
      if (rd_fire) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + ptr_w'(1);
      end
      // Simultaneous push and pop leave the count alone
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + cnt_w'(1);
        2'b01:   count <= count - cnt_w'(1);
        default: count <= count;
      endcase
    end
  end

endmodule : glay_fifo

//--- src/glay_kernel_cu.sv
`timescale 1ns/1ns

`include "glay_settings.svh"

module glay_kernel_cu (
  input  logic                     ap_clk,
  input  logic                     m_axi_areset,
  // Host control
  input  logic                     ap_start,
  output logic                     ap_idle,
  output logic                     ap_ready,
  output logic                     ap_done,
  // Work descriptor
  input  logic                     desc_valid,
  input  logic [`GLAY_ADDR_W-1:0]  desc_base_addr,
  input  logic [`GLAY_COUNT_W-1:0] desc_num_words,
  // Engine requests
  input  logic                     eng_req_valid,
  input  logic [`GLAY_ADDR_W-1:0]  eng_req_addr,
  output logic                     eng_req_ready,
  // Read address channel
  output logic                     ar_valid,
  output logic [`GLAY_ADDR_W-1:0]  ar_addr,
  output logic [`GLAY_ID_W-1:0]    ar_id,
  input  logic                     ar_ready,
  // Read data channel
  input  logic                     r_valid,
  input  logic [`GLAY_DATA_W-1:0]  r_data,
  input  logic [`GLAY_ID_W-1:0]    r_id,
  output logic                     r_ready,
  // Responses
  output logic                     resp_valid,
  output logic [`GLAY_DATA_W-1:0]  resp_data,
  output logic [`GLAY_ID_W-1:0]    resp_id,
  input  logic                     resp_ready
);

  import glay_pkg::*;

  logic                    rst;
  logic                    setup_start;
  glay_desc_t              setup_desc;
  logic                    setup_req_valid;
  logic                    setup_req_ready;
  logic [`GLAY_ADDR_W-1:0] setup_req_addr;
  logic                    arb_valid;
  logic                    arb_ready;
  glay_req_t               arb_req;
  glay_req_t               ar_req;
  glay_resp_t              r_resp;
  glay_resp_t              resp_out;
  logic                    resp_fire;

  // Single registered copy of reset for every stage
  always_ff @(posedge ap_clk) begin
    rst <= m_axi_areset;
  end

  // ------------------------------------------------------------
  // Control and setup request generation
  // ------------------------------------------------------------
  // Completion tracking sees beats as they leave the response port
  assign resp_fire = resp_valid && resp_ready;

  glay_control u_control (
    .ap_clk         (ap_clk),
    .rst            (rst),
    .ap_start       (ap_start),
    .ap_idle        (ap_idle),
    .ap_ready       (ap_ready),
    .ap_done        (ap_done),
    .desc_valid     (desc_valid),
    .desc_base_addr (desc_base_addr),
    .desc_num_words (desc_num_words),
    .resp_fire      (resp_fire),
    .resp_id        (resp_id),
    .setup_start    (setup_start),
    .setup_desc     (setup_desc)
  );

  glay_setup_reader u_setup_reader (
    .ap_clk    (ap_clk),
    .rst       (rst),
    .start     (setup_start),
    .desc      (setup_desc),
    .req_valid (setup_req_valid),
    .req_ready (setup_req_ready),
    .req_addr  (setup_req_addr)
  );

  // ------------------------------------------------------------
  // Request path to the ar channel
  // ------------------------------------------------------------
  // Input 0 setup, input 1 engine
  glay_req_arbiter u_req_arbiter (
    .ap_clk      (ap_clk),
    .rst         (rst),
    .setup_valid (setup_req_valid),
    .setup_ready (setup_req_ready),
    .setup_addr  (setup_req_addr),
    .eng_valid   (eng_req_valid),
    .eng_ready   (eng_req_ready),
    .eng_addr    (eng_req_addr),
    .out_valid   (arb_valid),
    .out_ready   (arb_ready),
    .out_req     (arb_req)
  );

  glay_fifo #(
    .payload_t (glay_req_t)
  ) u_req_fifo (
    .ap_clk    (ap_clk),
    .rst       (rst),
    .in_valid  (arb_valid),
    .in_ready  (arb_ready),
    .in_data   (arb_req),
    .out_valid (ar_valid),
    .out_ready (ar_ready),
    .out_data  (ar_req)
  );

  assign ar_addr = ar_req.addr;
  assign ar_id   = ar_req.id;

  // ------------------------------------------------------------
  // Response path from the r channel
  // ------------------------------------------------------------
  assign r_resp.data = r_data;
  assign r_resp.id   = r_id;

  glay_fifo #(
    .payload_t (glay_resp_t)
  ) u_resp_fifo (
    .ap_clk    (ap_clk),
    .rst       (rst),
    .in_valid  (r_valid),
    .in_ready  (r_ready),
    .in_data   (r_resp),
    .out_valid (resp_valid),
    .out_ready (resp_ready),
    .out_data  (resp_out)
  );

  assign resp_data = resp_out.data;
  assign resp_id   = resp_out.id;

endmodule : glay_kernel_cu

//--- src/glay_pkg.sv
package glay_pkg;

  `include "glay_settings.svh"

  // ------------------------------------------------------------
  // Work descriptor
  // ------------------------------------------------------------
  // Base byte address plus number of words to fetch
  typedef struct packed {
    logic [`GLAY_ADDR_W-1:0]  base_addr;
    logic [`GLAY_COUNT_W-1:0] num_words;
  } glay_desc_t;

  // ------------------------------------------------------------
  // Read request and response payloads
  // ------------------------------------------------------------
  // One read request, tagged with its source
  typedef struct packed {
    logic [`GLAY_ADDR_W-1:0] addr;
    logic [`GLAY_ID_W-1:0]   id;
  } glay_req_t;

  // Returned beat, tag travels back with the data
  typedef struct packed {
    logic [`GLAY_DATA_W-1:0] data;
    logic [`GLAY_ID_W-1:0]   id;
  } glay_resp_t;

endpackage : glay_pkg

//--- src/glay_req_arbiter.sv
`timescale 1ns/1ns

`include "glay_settings.svh"

module glay_req_arbiter (
  input  logic                    ap_clk,
  input  logic                    rst,
  input  logic                    setup_valid,
  output logic                    setup_ready,
  input  logic [`GLAY_ADDR_W-1:0] setup_addr,
  input  logic                    eng_valid,
  output logic                    eng_ready,
  input  logic [`GLAY_ADDR_W-1:0] eng_addr,
  output logic                    out_valid,
  input  logic                    out_ready,
  output glay_pkg::glay_req_t     out_req
);

  // Setup won the last transfer
  logic last_setup;
  logic grant_setup;
  logic out_fire;

  // ------------------------------------------------------------
  // Grant
  // ------------------------------------------------------------
  // Setup wins alone, or on a tie when engine went last
  // Engine holds the grant by default so its ready idles high
  assign grant_setup = setup_valid && (!eng_valid || !last_setup);

  assign setup_ready = out_ready && grant_setup;
  assign eng_ready   = out_ready && !grant_setup;

  assign out_valid = grant_setup ? setup_valid : eng_valid;
  assign out_fire  = out_valid && out_ready;

  // Merged request, tagged with its source
  always_comb begin
    if (grant_setup) begin
      out_req.addr = setup_addr;
      out_req.id   = `GLAY_ID_SETUP;
    end else begin
      out_req.addr = eng_addr;
      out_req.id   = `GLAY_ID_ENGINE;
    end
  end

  // ------------------------------------------------------------
  // Round-robin pointer
  // ------------------------------------------------------------
  // Moves away from the winner of each transfer
  // Under contention this alternates the two sources
  always_ff @(posedge ap_clk) begin
    if (rst) begin
      last_setup <= 1'b0;
    end else if (out_fire) begin
      last_setup <= grant_setup;
    end
  end

endmodule : glay_req_arbiter

//--- src/glay_settings.svh
`ifndef GLAY_SETTINGS_SVH
`define GLAY_SETTINGS_SVH

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------
// Byte address on the read address channel
`define GLAY_ADDR_W 32
// Read data beat
`define GLAY_DATA_W 64
// Requester tag carried with each request and response
`define GLAY_ID_W 1
// Descriptor word count
`define GLAY_COUNT_W 16

// Byte stride between consecutive setup words
`define GLAY_WORD_BYTES 8
// Entries in each request and response queue
`define GLAY_FIFO_DEPTH 4

// Requester IDs
`define GLAY_ID_SETUP 1'b0
`define GLAY_ID_ENGINE 1'b1

`endif

//--- src/glay_setup_reader.sv
`timescale 1ns/1ns

`include "glay_settings.svh"

module glay_setup_reader (
  input  logic                    ap_clk,
  input  logic                    rst,
  input  logic                    start,
  input  glay_pkg::glay_desc_t    desc,
  output logic                    req_valid,
  input  logic                    req_ready,
  output logic [`GLAY_ADDR_W-1:0] req_addr
);

  logic [`GLAY_COUNT_W-1:0] remaining;
  logic                     req_fire;

  // ------------------------------------------------------------
  // Request presentation
  // ------------------------------------------------------------
  // Valid straight from the counter, so it holds under back-pressure
  assign req_valid = (remaining != '0);
  assign req_fire  = req_valid && req_ready;

  // Words still to request for this descriptor
  always_ff @(posedge ap_clk) begin
    if (rst) begin
      remaining <= '0;
    end else if (start) begin
      remaining <= desc.num_words;
    end else if (req_fire) begin
      remaining <= remaining - `GLAY_COUNT_W'(1);
    end
  end

  // ------------------------------------------------------------
  // Address walk
  // ------------------------------------------------------------
  // Base on start, then one word stride per accepted request
  always_ff @(posedge ap_clk) begin
    if (start) begin
      req_addr <= desc.base_addr;
    end else if (req_fire) begin
      req_addr <= req_addr + `GLAY_ADDR_W'(`GLAY_WORD_BYTES);
    end
  end

endmodule : glay_setup_reader

//--- test/glay_kernel_cu_asserts.sv
`timescale 1ns/1ns

`include "glay_settings.svh"

module glay_kernel_cu_asserts (
  input logic                    ap_clk,
  input logic                    m_axi_areset,
  input logic                    rst,
  input logic                    ap_idle,
  input logic                    ap_ready,
  input logic                    ap_done,
  input logic                    ar_valid,
  input logic                    ar_ready,
  input logic [`GLAY_ADDR_W-1:0] ar_addr,
  input logic                    resp_valid,
  input logic                    resp_ready,
  input logic [`GLAY_DATA_W-1:0] resp_data
);

  // Running count of assertion failures
  int fail_count = 0;

  // ------------------------------------------------------------
  // Channel stability under back-pressure
  // ------------------------------------------------------------
  ar_hold: assert property (@(posedge ap_clk) disable iff (m_axi_areset || rst)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
    else begin
      $error("ar_valid or ar_addr changed before ar_ready");
      fail_count++;
    end

  resp_hold: assert property (@(posedge ap_clk) disable iff (m_axi_areset || rst)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_data))
    else begin
      $error("resp_valid or resp_data changed before resp_ready");
      fail_count++;
    end

  // ------------------------------------------------------------
  // Host control pulses
  // ------------------------------------------------------------
  done_pulse: assert property (@(posedge ap_clk) disable iff (m_axi_areset || rst)
    ap_done |=> !ap_done)
    else begin
      $error("ap_done held longer than one cycle");
      fail_count++;
    end

  ready_pulse: assert property (@(posedge ap_clk) disable iff (m_axi_areset || rst)
    ap_ready |=> !ap_ready)
    else begin
      $error("ap_ready held longer than one cycle");
      fail_count++;
    end

  // Done marks the end of a run, idle only afterwards
  done_then_idle: assert property (@(posedge ap_clk) disable iff (m_axi_areset || rst)
    ap_done |-> !ap_idle ##1 ap_idle)
    else begin
      $error("ap_idle high during ap_done or low right after it");
      fail_count++;
    end

endmodule : glay_kernel_cu_asserts

bind glay_kernel_cu glay_kernel_cu_asserts u_asserts (.*);

//--- test/glay_kernel_cu_tb.sv
`timescale 1ns/1ns

`include "glay_settings.svh"

module glay_kernel_cu_tb;

  localparam int num_tests = 8;
  localparam int max_eng   = 5;

  logic                     ap_clk;
  logic                     m_axi_areset;
  logic                     ap_start;
  logic                     ap_idle;
  logic                     ap_ready;
  logic                     ap_done;
  logic                     desc_valid;
  logic [`GLAY_ADDR_W-1:0]  desc_base_addr;
  logic [`GLAY_COUNT_W-1:0] desc_num_words;
  logic                     eng_req_valid;
  logic [`GLAY_ADDR_W-1:0]  eng_req_addr;
  logic                     eng_req_ready;
  logic                     ar_valid;
  logic [`GLAY_ADDR_W-1:0]  ar_addr;
  logic [`GLAY_ID_W-1:0]    ar_id;
  logic                     ar_ready;
  logic                     r_valid;
  logic [`GLAY_DATA_W-1:0]  r_data;
  logic [`GLAY_ID_W-1:0]    r_id;
  logic                     r_ready;
  logic                     resp_valid;
  logic [`GLAY_DATA_W-1:0]  resp_data;
  logic [`GLAY_ID_W-1:0]    resp_id;
  logic                     resp_ready;

  glay_kernel_cu dut (.*);

  // ------------------------------------------------------------
  // Testbench state
  // ------------------------------------------------------------
  int unsigned lcg_state;
  int          error_count = 0;
  int          check_count = 0;
  int          tests_failed = 0;
  string       cur_test;
  logic        plan_ready = 1'b0;

  // Per-test descriptors, drawn before reset
  int unsigned             test_words [num_tests];
  logic [`GLAY_ADDR_W-1:0] test_base [num_tests];
  int unsigned             test_eng [num_tests];

  // Expected ar addresses and resp data, one list per ID
  logic [`GLAY_ADDR_W-1:0] setup_exp [$];
  logic [`GLAY_ADDR_W-1:0] eng_exp [$];
  logic [`GLAY_DATA_W-1:0] setup_data_exp [$];
  logic [`GLAY_DATA_W-1:0] eng_data_exp [$];

  // Memory model, accepted reads in order
  logic [`GLAY_ADDR_W-1:0] mem_addr_q [$];
  logic [`GLAY_ID_W-1:0]   mem_id_q [$];
  int unsigned             r_wait = 0;

  logic        ar_fire = 1'b0;
  logic        r_fire = 1'b0;
  logic        resp_fire = 1'b0;
  logic        eng_fire = 1'b0;
  int unsigned cur_words = 0;
  int unsigned setup_resp_count = 0;
  int unsigned ready_count = 0;
  int unsigned done_count = 0;
  int unsigned eng_left = 0;
  logic        done_seen = 1'b0;
  logic        idle_watch = 1'b0;

  initial begin
    ap_clk = 1'b0;
    forever #20 ap_clk = ~ap_clk;
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper bits only, low LCG bits cycle quickly
  function automatic int unsigned rand_below(int unsigned n);
    return (lcg_next() >> 16) % n;
  endfunction

  // Memory contents: address joined with its inverse
  function automatic logic [`GLAY_DATA_W-1:0] mem_word(logic [`GLAY_ADDR_W-1:0] addr);
    return {addr, ~addr};
  endfunction

  task automatic report_mismatch(string what, logic [63:0] exp_val, logic [63:0] act_val);
    error_count++;
    $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp_val, act_val);
  endtask

  task automatic report_problem(string what);
    error_count++;
    $display("ERROR %s: %s", cur_test, what);
  endtask

  // ------------------------------------------------------------
  // Per-cycle scoreboard, sampled mid-cycle
  // ------------------------------------------------------------
  task automatic observe();
    logic [`GLAY_ADDR_W-1:0] exp_addr;
    logic [`GLAY_DATA_W-1:0] exp_data;
    ar_fire   = ar_valid && ar_ready;
    r_fire    = r_valid && r_ready;
    resp_fire = resp_valid && resp_ready;
    eng_fire  = eng_req_valid && eng_req_ready;
    // Idle from the cycle after ap_done
    if (idle_watch && !ap_idle) begin
      report_problem("ap_idle dropped after ap_done");
    end
    if (ap_ready) begin
      ready_count++;
    end
    if (ap_done) begin
      done_count++;
      done_seen  = 1'b1;
      idle_watch = 1'b1;
      check_count++;
      if (setup_resp_count != cur_words) begin
        report_mismatch("setup responses before ap_done", cur_words, setup_resp_count);
      end
    end
    if (eng_fire) begin
      eng_exp.push_back(eng_req_addr);
    end
    if (ar_fire) begin
      mem_addr_q.push_back(ar_addr);
      mem_id_q.push_back(ar_id);
      if (ar_id == `GLAY_ID_SETUP) begin
        if (setup_exp.size() == 0) begin
          report_problem("setup read request beyond the descriptor word count");
        end else begin
          exp_addr = setup_exp.pop_front();
          check_count++;
          if (ar_addr != exp_addr) begin
            report_mismatch("setup ar_addr", exp_addr, ar_addr);
          end
          setup_data_exp.push_back(mem_word(exp_addr));
        end
      end else begin
        if (eng_exp.size() == 0) begin
          report_problem("engine read request that was never issued");
        end else begin
          exp_addr = eng_exp.pop_front();
          check_count++;
          if (ar_addr != exp_addr) begin
            report_mismatch("engine ar_addr", exp_addr, ar_addr);
          end
          eng_data_exp.push_back(mem_word(exp_addr));
        end
      end
    end
    // Reply accepted, retire the head read
    if (r_fire) begin
      void'(mem_addr_q.pop_front());
      void'(mem_id_q.pop_front());
    end
    if (resp_fire) begin
      if (resp_id == `GLAY_ID_SETUP) begin
        setup_resp_count++;
        if (setup_data_exp.size() == 0) begin
          report_problem("setup response with no outstanding request");
        end else begin
          exp_data = setup_data_exp.pop_front();
          check_count++;
          if (resp_data != exp_data) begin
            report_mismatch("setup resp_data", exp_data, resp_data);
          end
        end
      end else begin
        if (eng_data_exp.size() == 0) begin
          report_problem("engine response with no outstanding request");
        end else begin
          exp_data = eng_data_exp.pop_front();
          check_count++;
          if (resp_data != exp_data) begin
            report_mismatch("engine resp_data", exp_data, resp_data);
          end
        end
      end
    end
  endtask

  // ------------------------------------------------------------
  // Random back-pressure, memory replies, engine traffic
  // ------------------------------------------------------------
  task automatic drive();
    ar_ready   = (rand_below(4) != 0);
    resp_ready = (rand_below(4) != 0);
    if (r_fire) begin
      r_valid = 1'b0;
    end
    // In-order reply after a short random wait
    if (!r_valid && mem_addr_q.size() != 0) begin
      if (r_wait == 0) begin
        r_valid = 1'b1;
        r_data  = mem_word(mem_addr_q[0]);
        r_id    = mem_id_q[0];
        r_wait  = rand_below(4);
      end else begin
        r_wait--;
      end
    end
    if (eng_fire) begin
      eng_req_valid = 1'b0;
    end
    // Engine valid and address hold until accepted
    if (!eng_req_valid && eng_left != 0 && rand_below(3) == 0) begin
      eng_req_valid = 1'b1;
      eng_req_addr  = lcg_next() & 32'hffff_fff8;
      eng_left--;
    end
  endtask

  task automatic step_cycle();
    @(negedge ap_clk);
    observe();
    @(posedge ap_clk);
    #5;
    drive();
  endtask

  function automatic logic test_drained();
    return done_seen && eng_left == 0 && !eng_req_valid && !r_valid &&
           setup_exp.size() == 0 && eng_exp.size() == 0 && mem_addr_q.size() == 0 &&
           setup_data_exp.size() == 0 && eng_data_exp.size() == 0;
  endfunction

  task automatic finish_test(int errors_before, string detail);
    if (error_count == errors_before) begin
      $display("%s: %s, ok", cur_test, detail);
    end else begin
      tests_failed++;
      $display("%s: %s, failed with %0d errors", cur_test, detail, error_count - errors_before);
    end
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin : main
    int errors_before;
    lcg_state      = 32'd90615;
    m_axi_areset   = 1'b1;
    ap_start       = 1'b0;
    desc_valid     = 1'b0;
    desc_base_addr = '0;
    desc_num_words = '0;
    eng_req_valid  = 1'b0;
    eng_req_addr   = '0;
    ar_ready       = 1'b0;
    r_valid        = 1'b0;
    r_data         = '0;
    r_id           = '0;
    resp_ready     = 1'b0;
    for (int t = 0; t < num_tests; t++) begin
      test_words[t] = 1 + rand_below(12);
      test_base[t]  = lcg_next() & 32'hffff_fff8;
      test_eng[t]   = rand_below(max_eng + 1);
    end
    plan_ready = 1'b1;
    repeat (10) @(posedge ap_clk);
    #5;
    m_axi_areset = 1'b0;

    // Outputs once the registered reset has released
    cur_test      = "reset_state";
    errors_before = error_count;
    repeat (2) step_cycle();
    @(negedge ap_clk);
    check_count += 7;
    if (ap_idle !== 1'b1) report_mismatch("ap_idle", 1, ap_idle);
    if (ap_done !== 1'b0) report_mismatch("ap_done", 0, ap_done);
    if (ap_ready !== 1'b0) report_mismatch("ap_ready", 0, ap_ready);
    if (ar_valid !== 1'b0) report_mismatch("ar_valid", 0, ar_valid);
    if (resp_valid !== 1'b0) report_mismatch("resp_valid", 0, resp_valid);
    if (eng_req_ready !== 1'b1) report_mismatch("eng_req_ready", 1, eng_req_ready);
    if (r_ready !== 1'b1) report_mismatch("r_ready", 1, r_ready);
    finish_test(errors_before, "idle outputs after reset");

    for (int t = 0; t < num_tests; t++) begin
      cur_test      = $sformatf("run%0d", t);
      errors_before = error_count;
      // Decoy descriptor first, the later write must win
      desc_valid     = 1'b1;
      desc_base_addr = ~test_base[t];
      desc_num_words = test_words[t] + 3;
      step_cycle();
      desc_base_addr = test_base[t];
      desc_num_words = test_words[t];
      step_cycle();
      desc_valid = 1'b0;
      for (int i = 0; i < test_words[t]; i++) begin
        setup_exp.push_back(test_base[t] + i * `GLAY_WORD_BYTES);
      end
      cur_words        = test_words[t];
      setup_resp_count = 0;
      ready_count      = 0;
      done_count       = 0;
      done_seen        = 1'b0;
      idle_watch       = 1'b0;
      eng_left         = test_eng[t];
      ap_start = 1'b1;
      step_cycle();
      ap_start = 0;
      while (ready_count == 0) begin
        step_cycle();
      end
      // Second start while busy, must be ignored
      ap_start = 1'b1;
      step_cycle();
      ap_start = 1'b0;
      while (!test_drained()) begin
        step_cycle();
      end
      // Room for stray pulses
      repeat (2) step_cycle();
      check_count += 2;
      if (ready_count != 1) report_mismatch("ap_ready pulses", 1, ready_count);
      if (done_count != 1) report_mismatch("ap_done pulses", 1, done_count);
      finish_test(errors_before,
                  $sformatf("%0d setup words, %0d engine reads", test_words[t], test_eng[t]));
    end

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d check errors, %0d assertion failures",
             num_tests + 1, tests_failed, check_count, error_count, dut.u_asserts.fail_count);
    if (error_count == 0 && dut.u_asserts.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Limit scales with the total setup words
  initial begin : watchdog
    int unsigned total_words;
    int unsigned limit;
    wait (plan_ready);
    total_words = 0;
    for (int i = 0; i < num_tests; i++) begin
      total_words += test_words[i];
    end
    limit = total_words * 60 + 2000;
    repeat (limit) @(posedge ap_clk);
    $display("Timeout: the tests did not finish within %0d clock cycles", limit);
    $display("Errors found");
    $finish;
  end

endmodule : glay_kernel_cu_tb

//--- vlog.f
+incdir+src
src/glay_pkg.sv
src/glay_control.sv
src/glay_setup_reader.sv
src/glay_req_arbiter.sv
src/glay_fifo.sv
src/glay_kernel_cu.sv
test/glay_kernel_cu_asserts.sv
test/glay_kernel_cu_tb.sv
